//--- retrosoc_asic.f
+incdir+include
hdl/bus_pkg.sv
hdl/hk_pkg.sv
hdl/rst_sync.sv
hdl/pin_sync.sv
hdl/hk_spi_slave.sv
hdl/hk_regs.sv
hdl/apb_periph.sv
hdl/spram_model.sv
hdl/retrosoc_asic.sv
tests/tb_retrosoc_asic.sv

//--- tests/tb_retrosoc_asic.sv
`timescale 1ns/1ps
`include "retrosoc_settings.svh"

module tb_retrosoc_asic;

  localparam int SCK_HALF    = 5;
  localparam int APB_TIMEOUT = 8;
  localparam int CLR_TIMEOUT = 50;
  localparam int WATCHDOG    = 100000;
  localparam int RAM_WRITES  = 64;
  localparam logic [11:0] MFGR = `MFGR_ID;

  logic           clk_i;
  logic           arst_n_i;
  logic           hk_sck_i;
  logic           hk_csb_i;
  logic           hk_sdi_i;
  logic           hk_sdo_o;
  logic           hk_sdo_oe_o;
  bus_pkg::gpio_t gpio_in_i;
  bus_pkg::gpio_t gpio_out_o;
  bus_pkg::gpio_t gpio_oe_o;
  bus_pkg::addr_t paddr_i;
  logic           psel_i;
  logic           penable_i;
  logic           pwrite_i;
  bus_pkg::data_t pwdata_i;
  bus_pkg::strb_t pstrb_i;
  bus_pkg::data_t prdata_o;
  logic           pready_o;
  logic           pslverr_o;
  logic           xtal_ena_o;
  logic [3:0]     pll_trim_o;
  logic           pll_bypass_o;
  logic           hk_irq_o;

  integer           seed;
  int               err_data;
  int               err_hk;
  int               err_bit;
  int               err_other;
  hk_pkg::hk_data_t hk_mirror [256];
  bus_pkg::data_t   ram_mirror [2**`RAM_AW];
  hk_pkg::hk_data_t spi_tx [16];
  hk_pkg::hk_data_t spi_rx [16];
  bus_pkg::data_t   gpio_out_exp;
  bus_pkg::data_t   gpio_oe_exp;

  retrosoc_asic UUT (
    .clk_i       (clk_i),
    .arst_n_i    (arst_n_i),
    .hk_sck_i    (hk_sck_i),
    .hk_csb_i    (hk_csb_i),
    .hk_sdi_i    (hk_sdi_i),
    .hk_sdo_o    (hk_sdo_o),
    .hk_sdo_oe_o (hk_sdo_oe_o),
    .gpio_in_i   (gpio_in_i),
    .gpio_out_o  (gpio_out_o),
    .gpio_oe_o   (gpio_oe_o),
    .paddr_i     (paddr_i),
    .psel_i      (psel_i),
    .penable_i   (penable_i),
    .pwrite_i    (pwrite_i),
    .pwdata_i    (pwdata_i),
    .pstrb_i     (pstrb_i),
    .prdata_o    (prdata_o),
    .pready_o    (pready_o),
    .pslverr_o   (pslverr_o),
    .xtal_ena_o  (xtal_ena_o),
    .pll_trim_o  (pll_trim_o),
    .pll_bypass_o(pll_bypass_o),
    .hk_irq_o    (hk_irq_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  // byte-lane merge of a bus write
  function automatic bus_pkg::data_t ram_expect(input bus_pkg::data_t old_val,
                                                input bus_pkg::data_t wdata,
                                                input bus_pkg::strb_t strb);
    bus_pkg::data_t res;
    res = old_val;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  // IDs and unused indices keep their value on a write
  function automatic hk_pkg::hk_data_t hk_expect(input hk_pkg::hk_addr_t addr,
                                                 input hk_pkg::hk_data_t old_val,
                                                 input hk_pkg::hk_data_t wdata);
    case (addr)
      hk_pkg::REG_XTAL_ENA, hk_pkg::REG_PLL_BYP, hk_pkg::REG_IRQ, hk_pkg::REG_SOFT_RST:
        return {7'h0, wdata[0]};
      hk_pkg::REG_PLL_TRIM:
        return {4'h0, wdata[3:0]};
      default:
        return old_val;
    endcase
  endfunction

  task automatic check_data(input string name, input bus_pkg::data_t exp,
                            input bus_pkg::data_t act);
    if (act !== exp) begin
      err_data++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_hk(input string name, input hk_pkg::hk_data_t exp,
                          input hk_pkg::hk_data_t act);
    if (act !== exp) begin
      err_hk++;
      $display("[ERROR] t=%0t %s expected %h actual %h", $time, name, exp, act);
    end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    if (act !== exp) begin
      err_bit++;
      $display("[ERROR] t=%0t %s expected %b actual %b", $time, name, exp, act);
    end
  endtask

  task automatic print_summary();
    $display("errors: data %0d, hk %0d, bit %0d, other %0d",
             err_data, err_hk, err_bit, err_other);
  endtask

  task automatic abort_run(input string why);
    err_other++;
    $display("t=%0t %s", $time, why);
    print_summary();
    $display("sim failed");
    $finish;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(posedge clk_i);
  endtask

  task automatic reset_mirrors();
    for (int i = 0; i < 256; i++) begin
      hk_mirror[i] = '0;
    end
    hk_mirror[hk_pkg::REG_MFGR_HI]  = {4'h0, MFGR[11:8]};
    hk_mirror[hk_pkg::REG_MFGR_LO]  = MFGR[7:0];
    hk_mirror[hk_pkg::REG_PROD_ID]  = `PROD_ID;
    hk_mirror[hk_pkg::REG_MASK_REV] = {4'h0, `MASK_REV};
    hk_mirror[hk_pkg::REG_XTAL_ENA] = 8'h01;
    hk_mirror[hk_pkg::REG_PLL_BYP]  = 8'h01;
    gpio_out_exp = '0;
    gpio_oe_exp  = '0;
  endtask

  // one setup cycle and access cycles until pready
  task automatic apb_xfer(input bus_pkg::addr_t addr, input logic write,
                          input bus_pkg::data_t wdata, input bus_pkg::strb_t strb,
                          output bus_pkg::data_t rdata, output logic err);
    int waited;
    waited = 0;
    rdata  = '0;
    err    = 1'b0;
    @(posedge clk_i);
    paddr_i   <= addr;
    psel_i    <= 1'b1;
    penable_i <= 1'b0;
    pwrite_i  <= write;
    pwdata_i  <= wdata;
    pstrb_i   <= write ? strb : '0;
    @(posedge clk_i);
    penable_i <= 1'b1;
    // slave outputs looked at mid-cycle
    @(negedge clk_i);
    while (!pready_o && waited < APB_TIMEOUT) begin
      @(negedge clk_i);
      waited++;
    end
    if (!pready_o) begin
      abort_run("APB transfer timed out waiting for pready");
    end else begin
      rdata = prdata_o;
      err   = pslverr_o;
      @(posedge clk_i);
      psel_i    <= 1'b0;
      penable_i <= 1'b0;
    end
  endtask

  // sdo sampled at the end of each mode-0 low phase
  task automatic shift_byte(input hk_pkg::hk_data_t tx, input logic oe_exp,
                            output hk_pkg::hk_data_t rx);
    rx = '0;
    for (int b = 7; b >= 0; b--) begin
      hk_sck_i <= 1'b0;
      hk_sdi_i <= tx[b];
      wait_cycles(SCK_HALF);
      rx[b] = hk_sdo_o;
      check_bit("hk_sdo_oe_o", oe_exp, hk_sdo_oe_o);
      hk_sck_i <= 1'b1;
      wait_cycles(SCK_HALF);
    end
  endtask

  task automatic spi_frame(input hk_pkg::hk_cmd_e cmd, input hk_pkg::hk_addr_t addr,
                           input int n);
    hk_pkg::hk_data_t unused;
    @(posedge clk_i);
    hk_csb_i <= 1'b0;
    hk_sck_i <= 1'b0;
    wait_cycles(SCK_HALF);
    shift_byte(cmd, 1'b0, unused);
    shift_byte(addr, 1'b0, unused);
    for (int i = 0; i < n; i++) begin
      shift_byte(spi_tx[i], cmd == hk_pkg::CMD_READ, spi_rx[i]);
    end
    hk_sck_i <= 1'b0;
    wait_cycles(SCK_HALF);
    hk_csb_i <= 1'b1;
    wait_cycles(SCK_HALF);
    check_bit("hk_sdo_oe_o", 1'b0, hk_sdo_oe_o);
  endtask

  task automatic write_hk_regs(input hk_pkg::hk_addr_t start, input int n);
    hk_pkg::hk_addr_t a;
    spi_frame(hk_pkg::CMD_WRITE, start, n);
    for (int i = 0; i < n; i++) begin
      a = start + i;
      hk_mirror[a] = hk_expect(a, hk_mirror[a], spi_tx[i]);
    end
  endtask

  task automatic read_hk_regs(input hk_pkg::hk_addr_t start, input int n);
    hk_pkg::hk_addr_t a;
    // sdi held low during read data bytes
    for (int i = 0; i < n; i++) begin
      spi_tx[i] = '0;
    end
    spi_frame(hk_pkg::CMD_READ, start, n);
    for (int i = 0; i < n; i++) begin
      a = start + i;
      check_hk($sformatf("hk_reg[%h]", a), hk_mirror[a], spi_rx[i]);
    end
  endtask

  task automatic verify_hk_pins();
    check_bit("xtal_ena_o", hk_mirror[hk_pkg::REG_XTAL_ENA][0], xtal_ena_o);
    check_hk("pll_trim_o", hk_mirror[hk_pkg::REG_PLL_TRIM], {4'h0, pll_trim_o});
    check_bit("pll_bypass_o", hk_mirror[hk_pkg::REG_PLL_BYP][0], pll_bypass_o);
    check_bit("hk_irq_o", hk_mirror[hk_pkg::REG_IRQ][0], hk_irq_o);
  endtask

  initial begin
    repeat (WATCHDOG) @(posedge clk_i);
    abort_run("watchdog expired before the test sequence finished");
  end

  initial begin
    bus_pkg::data_t     rdata;
    bus_pkg::data_t     wd;
    bus_pkg::strb_t     st;
    bus_pkg::gpio_t     gin;
    bus_pkg::addr_t     ram_addrs [RAM_WRITES];
    logic [`RAM_AW-1:0] word;
    logic               err;
    int                 waited;

    seed      = 32'h078e_5aa5;
    err_data  = 0;
    err_hk    = 0;
    err_bit   = 0;
    err_other = 0;
    arst_n_i  = 1'b0;
    hk_sck_i  = 1'b0;
    hk_csb_i  = 1'b1;
    hk_sdi_i  = 1'b0;
    gpio_in_i = '0;
    paddr_i   = '0;
    psel_i    = 1'b0;
    penable_i = 1'b0;
    pwrite_i  = 1'b0;
    pwdata_i  = '0;
    pstrb_i   = '0;
    reset_mirrors();
    wait_cycles(5);
    arst_n_i <= 1'b1;
    // both reset chains in series
    wait_cycles(2 * `RST_STAGES + 2);

    check_bit("pready_o", 1'b0, pready_o);
    check_bit("pslverr_o", 1'b0, pslverr_o);
    check_bit("hk_sdo_oe_o", 1'b0, hk_sdo_oe_o);
    check_data("gpio_oe_o", '0, bus_pkg::data_t'(gpio_oe_o));
    verify_hk_pins();
    read_hk_regs(hk_pkg::REG_MFGR_HI, 4);
    read_hk_regs(hk_pkg::REG_XTAL_ENA, 5);

    for (int i = 0; i < 4; i++) begin
      spi_tx[i] = $random(seed);
    end
    write_hk_regs(hk_pkg::REG_XTAL_ENA, 4);
    read_hk_regs(hk_pkg::REG_XTAL_ENA, 5);
    verify_hk_pins();
    for (int i = 0; i < 4; i++) begin
      spi_tx[i] = $random(seed);
    end
    write_hk_regs(hk_pkg::REG_MFGR_HI, 4);
    read_hk_regs(hk_pkg::REG_MFGR_HI, 4);

    for (int i = 0; i < RAM_WRITES; i++) begin
      word = $random(seed);
      wd   = $random(seed);
      st   = $random(seed);
      ram_addrs[i] = bus_pkg::addr_t'({word, 2'b00});
      apb_xfer(ram_addrs[i], 1'b1, wd, st, rdata, err);
      check_bit("pslverr_o", 1'b0, err);
      ram_mirror[word] = ram_expect(ram_mirror[word], wd, st);
    end
    for (int i = 0; i < RAM_WRITES; i++) begin
      word = ram_addrs[i][`RAM_AW+1:2];
      apb_xfer(ram_addrs[i], 1'b0, '0, '0, rdata, err);
      check_bit("pslverr_o", 1'b0, err);
      check_data($sformatf("prdata_o[%h]", ram_addrs[i]), ram_mirror[word], rdata);
    end

    wd = $random(seed);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b1, wd, 4'hf, rdata, err);
    check_bit("pslverr_o", 1'b0, err);
    gpio_out_exp = ram_expect(gpio_out_exp, wd, 4'hf) & 32'h0000_ffff;
    wd = $random(seed);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OE_OFS, 1'b1, wd, 4'hf, rdata, err);
    gpio_oe_exp = ram_expect(gpio_oe_exp, wd, 4'hf) & 32'h0000_ffff;
    // upper lane only
    wd = $random(seed);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b1, wd, 4'b0010, rdata, err);
    gpio_out_exp = ram_expect(gpio_out_exp, wd, 4'b0010) & 32'h0000_ffff;
    wait_cycles(1);
    check_data("gpio_out_o", gpio_out_exp, bus_pkg::data_t'(gpio_out_o));
    check_data("gpio_oe_o", gpio_oe_exp, bus_pkg::data_t'(gpio_oe_o));
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b0, '0, '0, rdata, err);
    check_data("prdata_o gpio_out", gpio_out_exp, rdata);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OE_OFS, 1'b0, '0, '0, rdata, err);
    check_data("prdata_o gpio_oe", gpio_oe_exp, rdata);
    @(posedge clk_i);
    gin = $random(seed);
    gpio_in_i <= gin;
    wait_cycles(3);
    apb_xfer(`APB_GPIO_BASE + `GPIO_IN_OFS, 1'b0, '0, '0, rdata, err);
    check_data("prdata_o gpio_in", bus_pkg::data_t'(gin), rdata);
    apb_xfer(`APB_GPIO_BASE + 32'hc, 1'b1, 32'hffff_ffff, 4'hf, rdata, err);
    check_bit("pslverr_o", 1'b1, err);
    apb_xfer(`APB_GPIO_BASE + 32'hc, 1'b0, '0, '0, rdata, err);
    check_bit("pslverr_o", 1'b1, err);
    check_data("prdata_o unmapped", '0, rdata);
    check_data("gpio_out_o", gpio_out_exp, bus_pkg::data_t'(gpio_out_o));

    spi_tx[0] = 8'h01;
    write_hk_regs(hk_pkg::REG_SOFT_RST, 1);
    gpio_out_exp = '0;
    gpio_oe_exp  = '0;
    waited = 0;
    while ((gpio_out_o !== '0 || gpio_oe_o !== '0) && waited < CLR_TIMEOUT) begin
      @(posedge clk_i);
      waited++;
    end
    if (gpio_out_o !== '0 || gpio_oe_o !== '0) begin
      abort_run("GPIO outputs did not clear under soft reset");
    end
    verify_hk_pins();
    read_hk_regs(hk_pkg::REG_XTAL_ENA, 5);
    // write is lost while the bus side is held in reset
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b1, 32'h0000_a5a5, 4'hf, rdata, err);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b0, '0, '0, rdata, err);
    check_data("prdata_o gpio_out", gpio_out_exp, rdata);

    spi_tx[0] = 8'h00;
    write_hk_regs(hk_pkg::REG_SOFT_RST, 1);
    wait_cycles(`RST_STAGES + 2);
    wd = $random(seed);
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b1, wd, 4'hf, rdata, err);
    gpio_out_exp = ram_expect(gpio_out_exp, wd, 4'hf) & 32'h0000_ffff;
    wait_cycles(1);
    check_data("gpio_out_o", gpio_out_exp, bus_pkg::data_t'(gpio_out_o));
    apb_xfer(`APB_GPIO_BASE + `GPIO_OUT_OFS, 1'b0, '0, '0, rdata, err);
    check_data("prdata_o gpio_out", gpio_out_exp, rdata);
    verify_hk_pins();

    print_summary();
    if (err_data + err_hk + err_bit + err_other == 0) begin
      $display("sim passed");
    end else begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

//--- hdl/retrosoc_asic.sv
`timescale 1ns/1ps
`include "retrosoc_settings.svh"

module retrosoc_asic (
  input  logic           clk_i,
  input  logic           arst_n_i,
  // housekeeping spi
  input  logic           hk_sck_i,
  input  logic           hk_csb_i,
  input  logic           hk_sdi_i,
  output logic           hk_sdo_o,
  output logic           hk_sdo_oe_o,
  // gpio
  input  bus_pkg::gpio_t gpio_in_i,
  output bus_pkg::gpio_t gpio_out_o,
  output bus_pkg::gpio_t gpio_oe_o,
  // apb slave
  input  bus_pkg::addr_t paddr_i,
  input  logic           psel_i,
  input  logic           penable_i,
  input  logic           pwrite_i,
  input  bus_pkg::data_t pwdata_i,
  input  bus_pkg::strb_t pstrb_i,
  output bus_pkg::data_t prdata_o,
  output logic           pready_o,
  output logic           pslverr_o,
  // housekeeping outputs
  output logic           xtal_ena_o,
  output logic [3:0]     pll_trim_o,
  output logic           pll_bypass_o,
  output logic           hk_irq_o
);

  logic               hk_rst_n;
  logic               sys_arst_n;
  logic               sys_rst_n;
  logic               soft_rst;
  hk_pkg::spi_pins_t  spi_sync;
  bus_pkg::gpio_t     gpio_sync;
  hk_pkg::hk_addr_t   reg_addr;
  logic               reg_wr_en;
  hk_pkg::hk_data_t   reg_wr_data;
  logic               reg_rd_en;
  hk_pkg::hk_data_t   reg_rd_data;
  logic [`RAM_AW-1:0] ram_addr;
  bus_pkg::strb_t     ram_wstrb;
  bus_pkg::data_t     ram_wdata;
  bus_pkg::data_t     ram_rdata;

  rst_sync #(.STAGE(`RST_STAGES)) u_hk_rst_sync (
    .clk_i   (clk_i),
    .arst_n_i(arst_n_i),
    .rst_n_o (hk_rst_n)
  );

  // soft reset from housekeeping holds the bus side only
  assign sys_arst_n = hk_rst_n & ~soft_rst;

  rst_sync #(.STAGE(`RST_STAGES)) u_sys_rst_sync (
    .clk_i   (clk_i),
    .arst_n_i(sys_arst_n),
    .rst_n_o (sys_rst_n)
  );

  pin_sync #(
    .T      (hk_pkg::spi_pins_t),
    .RST_VAL(hk_pkg::SPI_PINS_IDLE)
  ) u_spi_pin_sync (
    .clk_i   (clk_i),
    .arst_n_i(hk_rst_n),
    .d_i     ({hk_sck_i, hk_csb_i, hk_sdi_i}),
    .q_o     (spi_sync)
  );

  pin_sync #(.T(bus_pkg::gpio_t)) u_gpio_pin_sync (
    .clk_i   (clk_i),
    .arst_n_i(sys_rst_n),
    .d_i     (gpio_in_i),
    .q_o     (gpio_sync)
  );

  hk_spi_slave u_hk_spi_slave (
    .clk_i     (clk_i),
    .arst_n_i  (hk_rst_n),
    .sck_i     (spi_sync.sck),
    .csb_i     (spi_sync.csb),
    .sdi_i     (spi_sync.sdi),
    .sdo_o     (hk_sdo_o),
    .sdo_oe_o  (hk_sdo_oe_o),
    .reg_addr_o(reg_addr),
    .wr_en_o   (reg_wr_en),
    .wr_data_o (reg_wr_data),
    .rd_en_o   (reg_rd_en),
    .rd_data_i (reg_rd_data)
  );

  hk_regs u_hk_regs (
    .clk_i       (clk_i),
    .arst_n_i    (hk_rst_n),
    .reg_addr_i  (reg_addr),
    .wr_en_i     (reg_wr_en),
    .wr_data_i   (reg_wr_data),
    .rd_en_i     (reg_rd_en),
    .rd_data_o   (reg_rd_data),
    .xtal_ena_o  (xtal_ena_o),
    .pll_trim_o  (pll_trim_o),
    .pll_bypass_o(pll_bypass_o),
    .irq_o       (hk_irq_o),
    .soft_rst_o  (soft_rst)
  );

  apb_periph u_apb_periph (
    .clk_i      (clk_i),
    .arst_n_i   (sys_rst_n),
    .paddr_i    (paddr_i),
    .psel_i     (psel_i),
    .penable_i  (penable_i),
    .pwrite_i   (pwrite_i),
    .pwdata_i   (pwdata_i),
    .pstrb_i    (pstrb_i),
    .prdata_o   (prdata_o),
    .pready_o   (pready_o),
    .pslverr_o  (pslverr_o),
    .gpio_in_i  (gpio_sync),
    .gpio_out_o (gpio_out_o),
    .gpio_oe_o  (gpio_oe_o),
    .ram_addr_o (ram_addr),
    .ram_wstrb_o(ram_wstrb),
    .ram_wdata_o(ram_wdata),
    .ram_rdata_i(ram_rdata)
  );

  spram_model u_spram_model (
    .clk_i  (clk_i),
    .addr_i (ram_addr),
    .wstrb_i(ram_wstrb),
    .wdata_i(ram_wdata),
    .rdata_o(ram_rdata)
  );

endmodule

//--- hdl/spram_model.sv
`timescale 1ns/1ps
`include "retrosoc_settings.svh"

module spram_model (
  input  logic               clk_i,
  input  logic [`RAM_AW-1:0] addr_i,
  input  bus_pkg::strb_t     wstrb_i,
  input  bus_pkg::data_t     wdata_i,
  output bus_pkg::data_t     rdata_o
);

  bus_pkg::data_t mem_q [2**`RAM_AW];

  // byte lanes written independently
  always_ff @(posedge clk_i) begin
    for (int i = 0; i < 4; i++) begin
      if (wstrb_i[i]) begin
        mem_q[addr_i][8*i +: 8] <= wdata_i[8*i +: 8];
      end
    end
  end

  // registered read returns old data on a same-cycle write
  always_ff @(posedge clk_i) begin
    rdata_o <= mem_q[addr_i];
  end

endmodule

//--- hdl/apb_periph.sv
`timescale 1ns/1ps
`include "retrosoc_settings.svh"

module apb_periph (
  input  logic                clk_i,
  input  logic                arst_n_i,
  input  bus_pkg::addr_t      paddr_i,
  input  logic                psel_i,
  input  logic                penable_i,
  input  logic                pwrite_i,
  input  bus_pkg::data_t      pwdata_i,
  input  bus_pkg::strb_t      pstrb_i,
  output bus_pkg::data_t      prdata_o,
  output logic                pready_o,
  output logic                pslverr_o,
  input  bus_pkg::gpio_t      gpio_in_i,
  output bus_pkg::gpio_t      gpio_out_o,
  output bus_pkg::gpio_t      gpio_oe_o,
  output logic [`RAM_AW-1:0]  ram_addr_o,
  output bus_pkg::strb_t      ram_wstrb_o,
  output bus_pkg::data_t      ram_wdata_o,
  input  bus_pkg::data_t      ram_rdata_i
);

  bus_pkg::region_e region;
  bus_pkg::addr_t   gpio_ofs;
  bus_pkg::gpio_t   gpio_out_q;
  bus_pkg::gpio_t   gpio_oe_q;
  logic             access;
  logic             gpio_wr;
  logic             rd_wait_q;

  function automatic bus_pkg::gpio_t strb_merge(bus_pkg::gpio_t old_val, bus_pkg::data_t wdata,
                                                bus_pkg::strb_t strb);
    bus_pkg::gpio_t res;
    res = old_val;
    for (int b = 0; b < `GPIO_W / 8; b++) begin
      if (strb[b]) begin
        res[8*b +: 8] = wdata[8*b +: 8];
      end
    end
    return res;
  endfunction

  assign gpio_ofs = paddr_i - `APB_GPIO_BASE;

  always_comb begin
    region = bus_pkg::REG_NONE;
    if (paddr_i < `APB_GPIO_BASE) begin
      region = bus_pkg::REG_RAM;
    end else if (gpio_ofs inside {`GPIO_OUT_OFS, `GPIO_OE_OFS, `GPIO_IN_OFS}) begin
      region = bus_pkg::REG_GPIO;
    end
  end

  always_comb begin
    prdata_o = '0;
    if (region == bus_pkg::REG_RAM) begin
      prdata_o = ram_rdata_i;
    end else if (region == bus_pkg::REG_GPIO) begin
      case (gpio_ofs)
        `GPIO_OUT_OFS: prdata_o = bus_pkg::data_t'(gpio_out_q);
        `GPIO_OE_OFS:  prdata_o = bus_pkg::data_t'(gpio_oe_q);
        default:       prdata_o = bus_pkg::data_t'(gpio_in_i);
      endcase
    end
  end

  assign access  = psel_i & penable_i;
  assign gpio_wr = access & pwrite_i & (region == bus_pkg::REG_GPIO);

  // ram reads hold one extra access cycle for the registered output
  assign pready_o  = access & ((region != bus_pkg::REG_RAM) | pwrite_i | rd_wait_q);
  assign pslverr_o = pready_o & (region == bus_pkg::REG_NONE);

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      gpio_out_q <= '0;
      gpio_oe_q  <= '0;
      rd_wait_q  <= 1'b0;
    end else begin
      rd_wait_q <= access & ~pwrite_i & (region == bus_pkg::REG_RAM) & ~rd_wait_q;
      if (gpio_wr && gpio_ofs == `GPIO_OUT_OFS) begin
        gpio_out_q <= strb_merge(gpio_out_q, pwdata_i, pstrb_i);
      end
      if (gpio_wr && gpio_ofs == `GPIO_OE_OFS) begin
        gpio_oe_q <= strb_merge(gpio_oe_q, pwdata_i, pstrb_i);
      end
    end
  end

  assign gpio_out_o  = gpio_out_q;
  assign gpio_oe_o   = gpio_oe_q;
  assign ram_addr_o  = paddr_i[`RAM_AW+1:2];
  assign ram_wdata_o = pwdata_i;
  assign ram_wstrb_o = (access && pwrite_i && region == bus_pkg::REG_RAM) ? pstrb_i : '0;

  a_penable_psel: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    penable_i |-> psel_i);

  a_ready_bound: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    psel_i && !penable_i ##1 psel_i && penable_i |-> ##[0:1] pready_o);

endmodule

//--- hdl/hk_regs.sv
`timescale 1ns/1ps
`include "retrosoc_settings.svh"

module hk_regs (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  hk_pkg::hk_addr_t reg_addr_i,
  input  logic             wr_en_i,
  input  hk_pkg::hk_data_t wr_data_i,
  input  logic             rd_en_i,
  output hk_pkg::hk_data_t rd_data_o,
  output logic             xtal_ena_o,
  output logic [3:0]       pll_trim_o,
  output logic             pll_bypass_o,
  output logic             irq_o,
  output logic             soft_rst_o
);

  localparam logic [11:0] MFGR_ID = `MFGR_ID;

  logic             xtal_ena_q;
  logic [3:0]       pll_trim_q;
  logic             pll_bypass_q;
  logic             irq_q;
  logic             soft_rst_q;
  hk_pkg::hk_data_t rd_mux;
  hk_pkg::hk_data_t rd_data_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      xtal_ena_q   <= 1'b1;
      pll_trim_q   <= 4'h0;
      pll_bypass_q <= 1'b1;
      irq_q        <= 1'b0;
      soft_rst_q   <= 1'b0;
    end else if (wr_en_i) begin
      // id bytes and unused indices drop the write
      case (reg_addr_i)
        hk_pkg::REG_XTAL_ENA: xtal_ena_q   <= wr_data_i[0];
        hk_pkg::REG_PLL_TRIM: pll_trim_q   <= wr_data_i[3:0];
        hk_pkg::REG_PLL_BYP:  pll_bypass_q <= wr_data_i[0];
        hk_pkg::REG_IRQ:      irq_q        <= wr_data_i[0];
        hk_pkg::REG_SOFT_RST: soft_rst_q   <= wr_data_i[0];
        default: ;
      endcase
    end
  end

  always_comb begin
    case (reg_addr_i)
      hk_pkg::REG_MFGR_HI:  rd_mux = {4'h0, MFGR_ID[11:8]};
      hk_pkg::REG_MFGR_LO:  rd_mux = MFGR_ID[7:0];
      hk_pkg::REG_PROD_ID:  rd_mux = `PROD_ID;
      hk_pkg::REG_MASK_REV: rd_mux = {4'h0, `MASK_REV};
      hk_pkg::REG_XTAL_ENA: rd_mux = {7'h0, xtal_ena_q};
      hk_pkg::REG_PLL_TRIM: rd_mux = {4'h0, pll_trim_q};
      hk_pkg::REG_PLL_BYP:  rd_mux = {7'h0, pll_bypass_q};
      hk_pkg::REG_IRQ:      rd_mux = {7'h0, irq_q};
      hk_pkg::REG_SOFT_RST: rd_mux = {7'h0, soft_rst_q};
      default:              rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rd_data_q <= rd_mux;
    end
  end

  assign rd_data_o    = rd_data_q;
  assign xtal_ena_o   = xtal_ena_q;
  assign pll_trim_o   = pll_trim_q;
  assign pll_bypass_o = pll_bypass_q;
  assign irq_o        = irq_q;
  assign soft_rst_o   = soft_rst_q;

endmodule

//--- hdl/hk_spi_slave.sv
`timescale 1ns/1ps

module hk_spi_slave (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             sck_i,
  input  logic             csb_i,
  input  logic             sdi_i,
  output logic             sdo_o,
  output logic             sdo_oe_o,
  output hk_pkg::hk_addr_t reg_addr_o,
  output logic             wr_en_o,
  output hk_pkg::hk_data_t wr_data_o,
  output logic             rd_en_o,
  input  hk_pkg::hk_data_t rd_data_i
);

  typedef enum logic [1:0] {
    PH_CMD,
    PH_ADDR,
    PH_DATA
  } phase_e;

  logic             sck_q;
  logic             sck_rise;
  logic             sck_fall;
  logic             byte_done;
  logic             tx_active;
  logic [2:0]       bit_cnt_q;
  logic [6:0]       rx_q;
  logic [7:0]       rx_byte;
  logic [7:0]       tx_q;
  logic             sdo_q;
  logic             rd_en_q;
  logic             load_q;
  phase_e           phase_q;
  hk_pkg::hk_cmd_e  cmd_q;
  hk_pkg::hk_addr_t addr_q;

  assign sck_rise  = sck_i & ~sck_q;
  assign sck_fall  = ~sck_i & sck_q;
  assign byte_done = sck_rise & ~csb_i & (bit_cnt_q == 3'd7);
  assign rx_byte   = {rx_q, sdi_i};
  assign tx_active = ~csb_i & (phase_q == PH_DATA) & (cmd_q == hk_pkg::CMD_READ);

  // frame state cleared while csb is high
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      sck_q     <= 1'b0;
      bit_cnt_q <= '0;
      phase_q   <= PH_CMD;
      cmd_q     <= hk_pkg::CMD_NOP;
      addr_q    <= '0;
      rd_en_q   <= 1'b0;
      load_q    <= 1'b0;
    end else begin
      sck_q   <= sck_i;
      rd_en_q <= 1'b0;
      load_q  <= rd_en_q;
      if (csb_i) begin
        bit_cnt_q <= '0;
        phase_q   <= PH_CMD;
      end else if (sck_rise) begin
        bit_cnt_q <= bit_cnt_q + 3'd1;
      end
      if (byte_done) begin
        case (phase_q)
          PH_CMD: begin
            cmd_q   <= hk_pkg::hk_cmd_e'(rx_byte);
            phase_q <= PH_ADDR;
          end
          PH_ADDR: begin
            addr_q  <= rx_byte;
            phase_q <= PH_DATA;
            rd_en_q <= (cmd_q == hk_pkg::CMD_READ);
          end
          default: begin
            // next register is prefetched for reads
            addr_q  <= addr_q + 8'd1;
            rd_en_q <= (cmd_q == hk_pkg::CMD_READ);
          end
        endcase
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (sck_rise) begin
      rx_q <= rx_byte[6:0];
    end
  end

  // sdo moves on sck falling edges only
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_q  <= '0;
      sdo_q <= 1'b0;
    end else if (load_q) begin
      tx_q <= rd_data_i;
    end else if (sck_fall && tx_active) begin
      sdo_q <= tx_q[7];
      tx_q  <= {tx_q[6:0], 1'b0};
    end
  end

  assign sdo_o      = sdo_q;
  assign sdo_oe_o   = tx_active;
  assign reg_addr_o = addr_q;
  assign rd_en_o    = rd_en_q;
  assign wr_data_o  = rx_byte;
  assign wr_en_o    = byte_done & (phase_q == PH_DATA) & (cmd_q == hk_pkg::CMD_WRITE);

  // a new frame starts with the output enable and the write strobe low
  a_oe_in_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    csb_i |=> !sdo_oe_o);

  a_wr_in_frame: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    csb_i |=> !wr_en_o);

endmodule

//--- hdl/pin_sync.sv
`timescale 1ns/1ps

module pin_sync #(
  parameter type T       = logic,
  parameter T    RST_VAL = T'(0)
) (
  input  logic clk_i,
  input  logic arst_n_i,
  input  T     d_i,
  output T     q_o
);

  T meta_q;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      meta_q <= RST_VAL;
      q_o    <= RST_VAL;
    end else begin
      meta_q <= d_i;
      q_o    <= meta_q;
    end
  end

endmodule

//--- hdl/rst_sync.sv
`timescale 1ns/1ps

module rst_sync #(
  parameter int STAGE = 5
) (
  input  logic clk_i,
  input  logic arst_n_i,
  output logic rst_n_o
);

  logic [STAGE-1:0] chain_q;

  // assert at once, release through the chain
  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      chain_q <= '0;
    end else begin
      chain_q <= {chain_q[STAGE-2:0], 1'b1};
    end
  end

  assign rst_n_o = chain_q[STAGE-1];

  a_release_delay: assert property (@(posedge clk_i) $rose(arst_n_i) |-> !rst_n_o [*STAGE]);

endmodule

//--- hdl/hk_pkg.sv
package hk_pkg;

  typedef logic [7:0] hk_addr_t;
  typedef logic [7:0] hk_data_t;

  // anything not listed acts as a no-op
  typedef enum logic [7:0] {
    CMD_NOP   = 8'h00,
    CMD_READ  = 8'h40,
    CMD_WRITE = 8'h80
  } hk_cmd_e;

  typedef struct packed {
    logic sck;
    logic csb;
    logic sdi;
  } spi_pins_t;

  // idle bus with chip select released
  localparam spi_pins_t SPI_PINS_IDLE = '{sck: 1'b0, csb: 1'b1, sdi: 1'b0};

  // register indices
  localparam hk_addr_t REG_MFGR_HI  = 8'h00;
  localparam hk_addr_t REG_MFGR_LO  = 8'h01;
  localparam hk_addr_t REG_PROD_ID  = 8'h02;
  localparam hk_addr_t REG_MASK_REV = 8'h03;
  localparam hk_addr_t REG_XTAL_ENA = 8'h08;
  localparam hk_addr_t REG_PLL_TRIM = 8'h09;
  localparam hk_addr_t REG_PLL_BYP  = 8'h0A;
  localparam hk_addr_t REG_IRQ      = 8'h0B;
  localparam hk_addr_t REG_SOFT_RST = 8'h0C;

endpackage

//--- hdl/bus_pkg.sv
`include "retrosoc_settings.svh"

package bus_pkg;

  typedef logic [31:0] addr_t;
  typedef logic [31:0] data_t;
  typedef logic [3:0] strb_t;

  typedef logic [`GPIO_W-1:0] gpio_t;

  // target of an apb address
  typedef enum logic [1:0] {
    REG_RAM,
    REG_GPIO,
    REG_NONE
  } region_e;

endpackage

//--- include/retrosoc_settings.svh
`ifndef RETROSOC_SETTINGS_SVH
`define RETROSOC_SETTINGS_SVH

// chip identification read back over housekeeping SPI
`define MFGR_ID    12'h456
`define PROD_ID    8'h05
`define MASK_REV   4'h1

`define RST_STAGES 5

// word address bits of the ram based at address 0
`define RAM_AW     10
`define GPIO_W     16

// apb map
`define APB_GPIO_BASE 32'h0300_0000
`define GPIO_OUT_OFS  32'h0
`define GPIO_OE_OFS   32'h4
`define GPIO_IN_OFS   32'h8

`endif
